// ==== Makefile ====
# Verilator build and run of the reservation station testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run, and check $(LOG) for the pass line"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   show this list"

test:
	verilator --binary --timing --assert -f list.f --top-module rs_tb -Mdir obj_dir
	./obj_dir/Vrs_tb > $(LOG) 2>&1; cat $(LOG)
	grep -q "^test passed$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== list.f ====
source/rs_pkg.sv
source/psel_gen.sv
source/dispatch.sv
source/rs.sv
source/issue_select.sv
source/exec_pipe.sv
source/rs_top.sv
tests/rs_tb.sv

// ==== source/dispatch.sv ====
// Dispatch stage of the slice
// Physical tag ready table, station entry building with CDB bypass, stall

`timescale 1ns/1ps

module dispatch #(
    parameter int n = 2
) (
    input  logic                         clock,
    input  logic                         rst,
    input  logic                         mispredict,
    input  logic [n-1:0]                 in_valid,        // One level per lane
    input  rs_pkg::opcode_t [n-1:0]      in_op,
    input  rs_pkg::tag_t [n-1:0]         in_dest,
    input  rs_pkg::tag_t [n-1:0]         in_src1,
    input  rs_pkg::src_operand_u [n-1:0] in_src2,
    input  logic [n-1:0]                 in_src2_is_imm,
    input  logic [$clog2(n+1)-1:0]       free_count,      // Free slots, capped at n
    input  logic [n-1:0]                 cdb_valid,
    input  rs_pkg::tag_t [n-1:0]         cdb_tag,
    output logic                         stall,
    output logic [n-1:0]                 alloc_valid,
    output rs_pkg::rs_entry_t [n-1:0]    alloc_entries
);
    import rs_pkg::*;

    localparam int num_tags = 1 << tag_w;
    localparam int cnt_w    = $clog2(n+1);

    logic [num_tags-1:0] ready_tbl;   // One bit per physical tag
    logic [num_tags-1:0] ready_next;
    logic [cnt_w-1:0]    lane_cnt;    // Valid lanes this cycle

    // All or nothing, a group never splits across cycles
    assign lane_cnt    = cnt_w'($countones(in_valid));
    assign stall       = lane_cnt > free_count;
    assign alloc_valid = stall ? '0 : in_valid;

    //////////////////////////////////////////////////////////////////////
    // Entry building
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        logic rdy1;
        logic rdy2;
        for (int i = 0; i < n; i++) begin
            rdy1 = ready_tbl[in_src1[i]];
            rdy2 = ready_tbl[in_src2[i].tag];
            // Bypass tags broadcast this very cycle
            for (int c = 0; c < n; c++) begin
                if (cdb_valid[c] && cdb_tag[c] == in_src1[i]) rdy1 = 1'b1;
                if (cdb_valid[c] && cdb_tag[c] == in_src2[i].tag) rdy2 = 1'b1;
            end
            // An older lane in the same group produces this source
            for (int j = 0; j < i; j++) begin
                if (in_valid[j] && in_dest[j] == in_src1[i]) rdy1 = 1'b0;
                if (in_valid[j] && in_dest[j] == in_src2[i].tag) rdy2 = 1'b0;
            end
            alloc_entries[i].valid       = in_valid[i];
            alloc_entries[i].op          = in_op[i];
            alloc_entries[i].dest_tag    = in_dest[i];
            alloc_entries[i].src1_tag    = in_src1[i];
            alloc_entries[i].src1_ready  = rdy1;
            alloc_entries[i].src2        = in_src2[i];
            alloc_entries[i].src2_is_imm = in_src2_is_imm[i];
            alloc_entries[i].src2_ready  = in_src2_is_imm[i] || rdy2;  // Immediate is always ready
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Ready table
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ready_next = ready_tbl;
        for (int c = 0; c < n; c++) begin
            if (cdb_valid[c]) ready_next[cdb_tag[c]] = 1'b1;
        end
        // Reallocation beats a broadcast of the same tag
        for (int i = 0; i < n; i++) begin
            if (alloc_valid[i]) ready_next[in_dest[i]] = 1'b0;
        end
    end

    always_ff @(posedge clock) begin
        if (rst || mispredict) begin
            ready_tbl <= '1;  // Nothing in flight
        end else begin
            ready_tbl <= ready_next;
        end
    end

    // A stall only happens with fewer than n free slots, and then nothing is sent
    a_stall_blocks: assert property (@(posedge clock) disable iff (rst)
        stall |-> (alloc_valid == '0) && (free_count < cnt_w'(n)));

endmodule

// ==== source/exec_pipe.sv ====
// Fixed latency execution pipe
// exec_lat stages of n lanes, last stage drives the CDB

`timescale 1ns/1ps

module exec_pipe #(
    parameter int n        = 2,
    parameter int exec_lat = 2
) (
    input  logic                 clock,
    input  logic                 rst,
    input  logic                 mispredict,
    input  logic [n-1:0]         issue_valid,
    input  rs_pkg::tag_t [n-1:0] issue_dest,
    output logic [n-1:0]         cdb_valid,
    output rs_pkg::tag_t [n-1:0] cdb_tag
);
    import rs_pkg::*;

    logic [exec_lat-1:0][n-1:0] stage_valid;  // Up to exec_lat*n in flight
    tag_t [exec_lat-1:0][n-1:0] stage_tag;

    // Valid bits shift every cycle, a flush empties the whole pipe
    always_ff @(posedge clock) begin
        if (rst || mispredict) begin
            stage_valid <= '0;
        end else begin
            stage_valid[0] <= issue_valid;
            for (int s = 1; s < exec_lat; s++) begin
                stage_valid[s] <= stage_valid[s-1];
            end
        end
    end

    always_ff @(posedge clock) begin
        stage_tag[0] <= issue_dest;
        for (int s = 1; s < exec_lat; s++) begin
            stage_tag[s] <= stage_tag[s-1];
        end
    end

    // Issued in cycle c, broadcast in cycle c+exec_lat
    assign cdb_valid = stage_valid[exec_lat-1];
    assign cdb_tag   = stage_tag[exec_lat-1];

    // Each tag is in flight once, so two lanes never broadcast the same one
    for (genvar a = 0; a < n; a++) begin : g_cdb_a
        for (genvar b = a + 1; b < n; b++) begin : g_cdb_b
            a_cdb_unique: assert property (@(posedge clock) disable iff (rst)
                !(cdb_valid[a] && cdb_valid[b] && cdb_tag[a] == cdb_tag[b]));
        end
    end

endmodule

// ==== source/issue_select.sv ====
// Issue selection
// Picks up to n ready station entries, lowest slot first, and drives
// the issue lanes and the matching clear requests back to the station

`timescale 1ns/1ps

module issue_select #(
    parameter int n     = 2,
    parameter int rs_sz = 8
) (
    input  logic                            issue_enable,  // Low holds all issue
    input  rs_pkg::rs_entry_t [rs_sz-1:0]   entries,
    output logic [n-1:0]                    clear_valid,
    output logic [n-1:0][$clog2(rs_sz)-1:0] clear_idxs,
    output logic [n-1:0]                    issue_valid,
    output rs_pkg::opcode_t [n-1:0]         issue_op,
    output rs_pkg::tag_t [n-1:0]            issue_dest
);
    import rs_pkg::*;

    localparam int idx_w = $clog2(rs_sz);

    logic [rs_sz-1:0]        ready_req;  // Entries with both sources ready
    logic [n-1:0][rs_sz-1:0] gnt_bus;

    always_comb begin
        for (int j = 0; j < rs_sz; j++) begin
            ready_req[j] = issue_enable && entries[j].valid
                           && entries[j].src1_ready && entries[j].src2_ready;
        end
    end

    psel_gen #(
        .width(rs_sz),
        .reqs (n)
    ) i_issue_sel (
        .req    (ready_req),
        .gnt_bus(gnt_bus)
    );

    //////////////////////////////////////////////////////////////////////
    // Grant encode and lane drive
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        rs_entry_t pick;
        for (int k = 0; k < n; k++) begin
            clear_idxs[k] = '0;
            pick          = '0;
            // One-hot to index, grant is one-hot so at most one hit
            for (int j = 0; j < rs_sz; j++) begin
                if (gnt_bus[k][j]) begin
                    clear_idxs[k] = idx_w'(j);
                    pick          = entries[j];
                end
            end
            issue_valid[k] = |gnt_bus[k];
            issue_op[k]    = pick.op;
            issue_dest[k]  = pick.dest_tag;  // Goes down the exec pipe
        end
    end

    // An issued slot is freed at the next edge
    assign clear_valid = issue_valid;

endmodule

// ==== source/psel_gen.sv ====
// Multi-grant priority selector
// Up to reqs one-hot grants over a width-bit request, lowest index first

`timescale 1ns/1ps

module psel_gen #(
    parameter int width = 8,
    parameter int reqs  = 2
) (
    input  logic [width-1:0]           req,
    output logic [reqs-1:0][width-1:0] gnt_bus  // Grant k goes to the k-th set bit
);

    always_comb begin
        logic [width-1:0] remaining;
        remaining = req;
        for (int k = 0; k < reqs; k++) begin
            gnt_bus[k] = remaining & (~remaining + 1'b1);  // Isolate lowest set bit
            remaining  = remaining & ~gnt_bus[k];           // Drop it for the next grant
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    // Grants are one-hot or empty and never share a slot
    always_comb begin
        for (int a = 0; a < reqs; a++) begin
            assert ($onehot0(gnt_bus[a]))
                else $error("psel_gen grant %0d not one-hot", a);
            for (int b = a + 1; b < reqs; b++) begin
                assert ((gnt_bus[a] & gnt_bus[b]) == '0)
                    else $error("psel_gen grants %0d and %0d overlap", a, b);
            end
        end
    end

endmodule

// ==== source/rs.sv ====
// Reservation station
// Slot storage, allocation through psel_gen, CDB wakeup, clear on issue,
// flush on mispredict and running free slot count

`timescale 1ns/1ps

module rs #(
    parameter int n     = 2,
    parameter int rs_sz = 8
) (
    input  logic                              clock,
    input  logic                              rst,
    input  logic                              mispredict,
    input  logic [n-1:0]                      alloc_valid,
    input  rs_pkg::rs_entry_t [n-1:0]         alloc_entries,
    input  logic [n-1:0]                      cdb_valid,
    input  rs_pkg::tag_t [n-1:0]              cdb_tag,
    input  logic [n-1:0]                      clear_valid,   // Issued this cycle
    input  logic [n-1:0][$clog2(rs_sz)-1:0]   clear_idxs,
    output rs_pkg::rs_entry_t [rs_sz-1:0]     entries,
    output logic [$clog2(n+1)-1:0]            free_count
);
    import rs_pkg::*;

    localparam int cnt_w  = $clog2(n+1);
    localparam int free_w = $clog2(rs_sz+1);

    rs_entry_t [rs_sz-1:0]    rs_array;
    rs_entry_t [rs_sz-1:0]    rs_array_next;
    logic [rs_sz-1:0]         free_mask;       // Empty or being vacated
    logic [rs_sz-1:0]         alloc_hit;       // Slots written this cycle
    logic [n-1:0][rs_sz-1:0]  gnt_bus;
    logic [free_w-1:0]        effective_free;  // Uncapped free slot count
    logic [free_w-1:0]        free_next;

    psel_gen #(
        .width(rs_sz),
        .reqs (n)
    ) i_alloc_sel (
        .req    (free_mask),
        .gnt_bus(gnt_bus)
    );

    // Slots issued this cycle can be refilled at the same edge
    always_comb begin
        for (int i = 0; i < rs_sz; i++) begin
            free_mask[i] = !rs_array[i].valid;
        end
        for (int i = 0; i < n; i++) begin
            if (clear_valid[i]) free_mask[clear_idxs[i]] = 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Next state of the slots
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        int unsigned g;
        rs_array_next = rs_array;
        alloc_hit     = '0;
        g             = 0;

        for (int i = 0; i < n; i++) begin
            if (clear_valid[i]) rs_array_next[clear_idxs[i]].valid = 1'b0;
        end

        // The k-th valid lane takes grant k, so a sparse lane mask still fits
        for (int i = 0; i < n; i++) begin
            if (alloc_valid[i]) begin
                for (int j = 0; j < rs_sz; j++) begin
                    if (gnt_bus[g][j]) begin
                        rs_array_next[j] = alloc_entries[i];
                        alloc_hit[j]     = 1'b1;
                    end
                end
                g++;
            end
        end

        // Associative wakeup, immediates never match
        for (int j = 0; j < rs_sz; j++) begin
            for (int c = 0; c < n; c++) begin
                if (rs_array_next[j].valid && cdb_valid[c]) begin
                    if (rs_array_next[j].src1_tag == cdb_tag[c])
                        rs_array_next[j].src1_ready = 1'b1;
                    if (!rs_array_next[j].src2_is_imm && rs_array_next[j].src2.tag == cdb_tag[c])
                        rs_array_next[j].src2_ready = 1'b1;
                end
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Free count and storage
    //////////////////////////////////////////////////////////////////////

    assign free_next  = effective_free + free_w'($countones(clear_valid))
                        - free_w'($countones(alloc_valid));
    assign free_count = (effective_free > free_w'(n)) ? cnt_w'(n) : cnt_w'(effective_free);
    assign entries    = rs_array;

    always_ff @(posedge clock) begin
        if (rst || mispredict) begin
            effective_free <= free_w'(rs_sz);
            for (int j = 0; j < rs_sz; j++) begin
                rs_array[j].valid <= 1'b0;  // Payload left as is
            end
        end else begin
            effective_free <= free_next;
            rs_array       <= rs_array_next;
        end
    end

    // Every lane dispatch let through gets its own free slot
    a_alloc_free: assert property (@(posedge clock) disable iff (rst || mispredict)
        ((alloc_hit & ~free_mask) == '0) && ($countones(alloc_hit) == $countones(alloc_valid)));

    // Issue only clears slots that hold an instruction
    for (genvar i = 0; i < n; i++) begin : g_clear_chk
        a_clear_live: assert property (@(posedge clock) disable iff (rst)
            clear_valid[i] |-> rs_array[clear_idxs[i]].valid);
    end

endmodule

// ==== source/rs_pkg.sv ====
// Shared types for the reservation station slice
// Tag and immediate widths, opcode type, src2 operand union and station entry

package rs_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////////////////////////

    localparam int tag_w = 5;  // 32 physical tags
    localparam int imm_w = 5;  // Same as tag_w so both union members line up

    typedef logic [tag_w-1:0] tag_t;     // Physical tag number
    typedef logic [2:0]       opcode_t;  // Carried through to the issue lanes only

    //////////////////////////////////////////////////////////////////////
    // Operand and entry types
    //////////////////////////////////////////////////////////////////////

    // Second source word, read as a tag or an immediate
    // The entry flag src2_is_imm picks the reading
    typedef union packed {
        tag_t             tag;  // Producer tag
        logic [imm_w-1:0] imm;  // Literal operand
    } src_operand_u;

    // One station slot
    typedef struct packed {
        logic         valid;        // Slot holds a waiting instruction
        opcode_t      op;
        tag_t         dest_tag;     // Broadcast on the CDB when done
        tag_t         src1_tag;
        logic         src1_ready;
        src_operand_u src2;
        logic         src2_is_imm;  // Immediate src2 needs no wakeup
        logic         src2_ready;
    } rs_entry_t;

endpackage

// ==== source/rs_top.sv ====
// Top level of the out-of-order issue slice
// dispatch, reservation station, issue select and execution pipe

`timescale 1ns/1ps

module rs_top #(
    parameter int n        = 2,  // Dispatch, issue and CDB width
    parameter int rs_sz    = 8,  // Station slots
    parameter int exec_lat = 2   // Cycles from issue to CDB
) (
    input  logic                         clock,
    input  logic                         rst,
    input  logic [n-1:0]                 in_valid,
    input  rs_pkg::opcode_t [n-1:0]      in_op,
    input  rs_pkg::tag_t [n-1:0]         in_dest,
    input  rs_pkg::tag_t [n-1:0]         in_src1,
    input  rs_pkg::src_operand_u [n-1:0] in_src2,
    input  logic [n-1:0]                 in_src2_is_imm,
    input  logic                         issue_enable,
    input  logic                         mispredict,    // One cycle flush pulse
    output logic                         stall,
    output logic [n-1:0]                 issue_valid,
    output rs_pkg::opcode_t [n-1:0]      issue_op,
    output rs_pkg::tag_t [n-1:0]         issue_dest,
    output logic [n-1:0]                 cdb_valid,
    output rs_pkg::tag_t [n-1:0]         cdb_tag
);
    import rs_pkg::*;

    logic [n-1:0]                    alloc_valid;
    rs_entry_t [n-1:0]               alloc_entries;
    logic [$clog2(n+1)-1:0]          free_count;
    rs_entry_t [rs_sz-1:0]           entries;
    logic [n-1:0]                    clear_valid;
    logic [n-1:0][$clog2(rs_sz)-1:0] clear_idxs;

    dispatch #(.n(n)) i_dispatch (
        .clock, .rst, .mispredict,
        .in_valid, .in_op, .in_dest, .in_src1, .in_src2, .in_src2_is_imm,
        .free_count, .cdb_valid, .cdb_tag,
        .stall, .alloc_valid, .alloc_entries
    );

    rs #(.n(n), .rs_sz(rs_sz)) i_rs (
        .clock, .rst, .mispredict,
        .alloc_valid, .alloc_entries,
        .cdb_valid, .cdb_tag,
        .clear_valid, .clear_idxs,
        .entries, .free_count
    );

    issue_select #(.n(n), .rs_sz(rs_sz)) i_issue_select (
        .issue_enable, .entries,
        .clear_valid, .clear_idxs,
        .issue_valid, .issue_op, .issue_dest
    );

    // CDB feeds back to both the station and the ready table
    exec_pipe #(.n(n), .exec_lat(exec_lat)) i_exec_pipe (
        .clock, .rst, .mispredict,
        .issue_valid, .issue_dest,
        .cdb_valid, .cdb_tag
    );

endmodule

// ==== tests/rs_tb.sv ====
// Testbench for rs_top
// Directed tests, tag level reference model, watchdog and error count

`timescale 1ns/1ps

module rs_tb;
    import rs_pkg::*;

    logic                    clock = 1'b0;
    logic                    rst;
    logic [1:0]              in_valid;
    opcode_t [1:0]           in_op;
    tag_t [1:0]              in_dest;
    tag_t [1:0]              in_src1;
    src_operand_u [1:0]      in_src2;
    logic [1:0]              in_src2_is_imm;
    logic                    issue_enable;
    logic                    mispredict;
    logic                    stall;
    logic [1:0]              issue_valid;
    opcode_t [1:0]           issue_op;
    tag_t [1:0]              issue_dest;
    logic [1:0]              cdb_valid;
    tag_t [1:0]              cdb_tag;

    // Model state, indexed by tag
    int      errors = 0;
    int      cyc = 0;
    int      occ = 0;       // Entries held in the station
    int      n_acc = 0;     // Accepted instructions
    int      state [32];    // 0 free, 1 waiting, 2 in the pipe
    logic    mready [32];
    logic    s1ok [32];
    logic    s2ok [32];
    tag_t    src1_of [32];
    tag_t    src2_of [32];
    logic    imm_of [32];
    opcode_t op_of [32];
    int      acc_edge [32];  // Edge that accepted the tag
    int      iss_cyc [32];
    int      cdb_cyc [32];

    rs_top i_dut (.*);

    always #4 clock = ~clock;               // 8 ns period
    always @(posedge clock) cyc <= cyc + 1;

    task automatic value_error(input string name, input int got, input int exp);
        $display("[ERROR] %0t %s got %0d expected %0d", $time, name, got, exp);
        errors++;
    endtask

    task automatic plain_error(input string what);
        $display("[ERROR] %0t %s", $time, what);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////////////
    // Reference model, sampled mid cycle where outputs are stable
    ////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        int   nv;
        int   fr;
        tag_t d;
        if (rst) begin
            occ = 0;
            for (int t = 0; t < 32; t++) begin
                state[t]  = 0;
                mready[t] = 1'b1;
            end
        end else begin
            nv = $countones(in_valid);
            fr = (8 - occ > 2) ? 2 : 8 - occ;
            if (stall !== (nv > fr)) value_error("stall", int'(stall), int'(nv > fr));
            for (int k = 0; k < 2; k++) begin
                if (issue_valid[k]) begin
                    d = issue_dest[k];
                    $display("cycle %0d issue tag %0d", cyc, d);
                    if (state[d] != 1) plain_error("issue of a tag that is not waiting");
                    else if (!s1ok[d] || !s2ok[d]) plain_error("issue before sources ready");
                    if (issue_op[k] !== op_of[d]) value_error("issue_op", issue_op[k], op_of[d]);
                    state[d]   = 2;
                    iss_cyc[d] = cyc;
                    occ--;
                end
            end
            for (int k = 0; k < 2; k++) begin
                if (cdb_valid[k]) begin
                    d = cdb_tag[k];
                    $display("cycle %0d cdb tag %0d", cyc, d);
                    if (state[d] != 2) plain_error("CDB broadcast of a tag not in the pipe");
                    else if (cyc != iss_cyc[d] + 2) value_error("cdb cycle", cyc, iss_cyc[d] + 2);
                    state[d]   = 0;
                    cdb_cyc[d] = cyc;
                    mready[d]  = 1'b1;
                    for (int t = 0; t < 32; t++) begin
                        if (state[t] == 1 && src1_of[t] == d) s1ok[t] = 1'b1;
                        if (state[t] == 1 && !imm_of[t] && src2_of[t] == d) s2ok[t] = 1'b1;
                    end
                end
            end
            if (mispredict) begin
                occ = 0;
                for (int t = 0; t < 32; t++) begin
                    state[t]  = 0;
                    mready[t] = 1'b1;
                end
            end else if (!stall) begin
                for (int k = 0; k < 2; k++) begin
                    if (in_valid[k]) begin
                        d = in_dest[k];
                        s1ok[d]     = mready[in_src1[k]];    // CDB already applied, so bypass
                        s2ok[d]     = in_src2_is_imm[k] || mready[in_src2[k].tag];
                        src1_of[d]  = in_src1[k];
                        src2_of[d]  = in_src2[k].tag;
                        imm_of[d]   = in_src2_is_imm[k];
                        op_of[d]    = in_op[k];
                        mready[d]   = 1'b0;                  // After reading sources
                        state[d]    = 1;
                        acc_edge[d] = cyc + 1;
                        occ++;
                        n_acc++;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////////////

    task automatic clear_log();
        for (int t = 0; t < 32; t++) begin
            acc_edge[t] = -1;
            iss_cyc[t]  = -1;
            cdb_cyc[t]  = -1;
        end
    endtask

    // Call right after a rising edge
    task automatic set_lane(input int k, input int op, input int dest, input int s1,
                            input int s2, input logic imm);
        in_op[k]          <= opcode_t'(op);
        in_dest[k]        <= tag_t'(dest);
        in_src1[k]        <= tag_t'(s1);
        in_src2[k].tag    <= tag_t'(s2);
        in_src2_is_imm[k] <= imm;
    endtask

    // Holds the lanes until the edge that takes them
    task automatic present(input logic [1:0] mask);
        int w;
        w = 0;
        in_valid <= mask;
        @(negedge clock);
        while (stall && w < 50) begin
            @(negedge clock);
            w++;
        end
        if (stall) plain_error("dispatch stayed stalled");
        @(posedge clock);
        in_valid <= '0;
    endtask

    task automatic wait_cdb(input int t);
        int w;
        w = 0;
        while (cdb_cyc[t] < 0 && w < 60) begin
            @(negedge clock);
            w++;
        end
        if (cdb_cyc[t] < 0) plain_error($sformatf("tag %0d never reached the CDB", t));
    endtask

    ////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////

    task automatic reset_idle();
        repeat (10) begin
            @(negedge clock);
            if (stall || issue_valid != 0 || cdb_valid != 0)
                plain_error("output active while idle after reset");
        end
    endtask

    task automatic single_independent();
        clear_log();
        @(posedge clock);
        issue_enable <= 1'b1;
        set_lane(0, 5, 3, 0, 7, 1'b1);
        present(2'b01);
        wait_cdb(3);
        if (iss_cyc[3] != acc_edge[3]) value_error("issue cycle tag 3", iss_cyc[3], acc_edge[3]);
    endtask

    task automatic dependency_chain();
        clear_log();
        @(posedge clock);
        set_lane(0, 1, 1, 0, 2, 1'b1);        // A
        present(2'b01);
        @(posedge clock);
        set_lane(0, 2, 2, 1, 3, 1'b1);        // B reads A
        present(2'b01);
        @(posedge clock);
        set_lane(0, 3, 4, 0, 2, 1'b0);        // C reads B in tag src2
        present(2'b01);
        wait_cdb(4);
        if (iss_cyc[2] != cdb_cyc[1] + 1) value_error("issue cycle B", iss_cyc[2], cdb_cyc[1] + 1);
        if (iss_cyc[4] != cdb_cyc[2] + 1) value_error("issue cycle C", iss_cyc[4], cdb_cyc[2] + 1);
        // Consumer presented in the broadcast cycle of its producer
        @(posedge clock);
        set_lane(0, 4, 6, 0, 1, 1'b1);
        present(2'b01);
        @(posedge clock);
        @(posedge clock);
        set_lane(0, 5, 7, 6, 1, 1'b1);
        present(2'b01);
        wait_cdb(7);
        if (acc_edge[7] != cdb_cyc[6] + 1) plain_error("bypass case not presented with broadcast");
        if (iss_cyc[7] != cdb_cyc[6] + 1) value_error("issue cycle bypass", iss_cyc[7], cdb_cyc[6] + 1);
    endtask

    task automatic fill_and_drain();
        clear_log();
        @(posedge clock);
        issue_enable <= 1'b0;
        for (int i = 0; i < 8; i++) begin
            if (i > 0) @(posedge clock);
            set_lane(0, i, 8 + i, 0, i, 1'b1);
            present(2'b01);
        end
        @(posedge clock);
        set_lane(0, 7, 16, 0, 0, 1'b1);
        in_valid <= 2'b01;
        @(negedge clock);
        if (!stall) value_error("stall on ninth", 0, 1);
        @(posedge clock);
        in_valid     <= '0;                     // Withdraw the ninth
        issue_enable <= 1'b1;
        wait_cdb(15);
        for (int k = 0; k < 4; k++) begin
            if (iss_cyc[8 + 2*k] != iss_cyc[9 + 2*k]) plain_error("drain pair split");
            if (k > 0 && iss_cyc[8 + 2*k] != iss_cyc[6 + 2*k] + 1) plain_error("drain out of order");
        end
    endtask

    task automatic flush_on_mispredict();
        int t0;
        clear_log();
        @(posedge clock);
        issue_enable <= 1'b0;
        set_lane(0, 1, 18, 0, 0, 1'b1);
        set_lane(1, 1, 19, 0, 0, 1'b1);
        present(2'b11);
        for (int i = 0; i < 5; i++) begin
            @(posedge clock);
            set_lane(0, 2, 20 + i, 18, 0, 1'b1);  // Waits on tag 18
            present(2'b01);
        end
        @(posedge clock);
        issue_enable <= 1'b1;                   // 18 and 19 go to the pipe
        @(posedge clock);
        mispredict <= 1'b1;
        @(posedge clock);
        mispredict <= 1'b0;
        repeat (5) begin
            @(negedge clock);
            if (issue_valid != 0 || cdb_valid != 0) plain_error("activity after flush");
        end
        if (iss_cyc[18] < 0 || cdb_cyc[18] >= 0) plain_error("tag 18 not flushed from the pipe");
        @(posedge clock);
        t0 = cyc;
        set_lane(0, 6, 25, 18, 0, 1'b1);         // Flushed tag reads as ready
        set_lane(1, 6, 26, 0, 19, 1'b0);
        present(2'b11);
        wait_cdb(26);
        if (acc_edge[25] != t0 + 2) value_error("accept edge after flush", acc_edge[25], t0 + 2);
        if (iss_cyc[25] != acc_edge[25]) value_error("issue after flush", iss_cyc[25], acc_edge[25]);
        if (iss_cyc[26] != acc_edge[26])
            value_error("issue after flush src2", iss_cyc[26], acc_edge[26]);
    endtask

    task automatic random_stream();
        tag_t recent [8];
        int   base;
        int   w;
        int   pick;
        int   taken;    // Dest already given to lane 0 in this group
        logic held;
        for (int i = 0; i < 8; i++) recent[i] = tag_t'(i);
        base = n_acc;
        held = 1'b0;
        w    = 0;
        while (n_acc - base < 300 && w < 2000) begin
            @(posedge clock);
            issue_enable <= ($urandom % 4) != 0;
            if (!held) begin
                in_valid <= '0;
                taken = -1;
                for (int k = 0; k < 2; k++) begin
                    pick = -1;
                    for (int tries = 0; tries < 32 && pick < 0; tries++) begin
                        pick = $urandom % 32;
                        if (state[pick] != 0 || pick == taken)
                            pick = -1;
                    end
                    if (pick >= 0 && ($urandom % 4) != 0) begin
                        set_lane(k, $urandom % 8, pick, recent[$urandom % 8],
                                 recent[$urandom % 8], ($urandom % 2) == 0);
                        in_valid[k] <= 1'b1;
                        recent[$urandom % 8] = tag_t'(pick);
                        taken = pick;
                    end
                end
            end
            @(negedge clock);
            held = stall;
            w++;
        end
        @(posedge clock);
        in_valid     <= '0;
        issue_enable <= 1'b1;
        repeat (40) @(posedge clock);
        if (n_acc - base < 300) plain_error("random stream accepted too few instructions");
        for (int t = 0; t < 32; t++) begin
            if (state[t] != 0) plain_error($sformatf("tag %0d never broadcast", t));
        end
    endtask

    // Watchdog over the summed test lengths
    initial begin
        repeat (3000) @(posedge clock);
        $display("[ERROR] %0t run exceeded 3000 cycles", $time);
        $display("test failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h27bd8e7b));
        rst            = 1'b1;
        in_valid       = '0;
        in_op          = '0;
        in_dest        = '0;
        in_src1        = '0;
        in_src2        = '0;
        in_src2_is_imm = '0;
        issue_enable   = 1'b0;
        mispredict     = 1'b0;
        clear_log();
        repeat (4) @(posedge clock);
        rst <= 1'b0;
        reset_idle();
        single_independent();
        dependency_chain();
        fill_and_drain();
        flush_on_mispredict();
        random_stream();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
